// ==== include/sample_disc_config.svh ====
`ifndef SAMPLE_DISC_CONFIG_SVH
`define SAMPLE_DISC_CONFIG_SVH

// adc channels and digital trigger inputs
`define DISC_CHANNELS 2
`define DISC_DIGITAL_CHANNELS 2

// one beat is PARALLEL_SAMPLES signed samples
`define DISC_SAMPLE_WIDTH 16
`define DISC_PARALLEL_SAMPLES 4

// delay capacity in adc_clk cycles
`define DISC_MAX_DELAY 16
`define DISC_DELAY_WIDTH $clog2(`DISC_MAX_DELAY)
// derived delays carry one extra bit for the sums
`define DISC_DERIVED_WIDTH (`DISC_DELAY_WIDTH + 1)

// trigger source numbers cover analog channels then digital inputs
`define DISC_SOURCE_WIDTH $clog2(`DISC_CHANNELS + `DISC_DIGITAL_CHANNELS)

`define DISC_TIME_WIDTH 32
`define DISC_INDEX_WIDTH 16

`endif

// ==== verilog/sample_disc_pkg.sv ====
`default_nettype none
`include "sample_disc_config.svh"

package sample_disc_pkg;

  typedef logic [`DISC_PARALLEL_SAMPLES-1:0][`DISC_SAMPLE_WIDTH-1:0] sample_beat_t;

  typedef struct packed {
    sample_beat_t [`DISC_CHANNELS-1:0] data;
    logic [`DISC_CHANNELS-1:0] valid;
  } adc_bus_t;

  // signed thresholds per channel
  typedef struct packed {
    logic [`DISC_CHANNELS-1:0][`DISC_SAMPLE_WIDTH-1:0] high;
    logic [`DISC_CHANNELS-1:0][`DISC_SAMPLE_WIDTH-1:0] low;
  } threshold_cfg_t;

  typedef struct packed {
    logic [`DISC_CHANNELS-1:0][`DISC_DELAY_WIDTH-1:0] start_delay;
    logic [`DISC_CHANNELS-1:0][`DISC_DELAY_WIDTH-1:0] stop_delay;
    // indexed by digital input
    logic [`DISC_DIGITAL_CHANNELS-1:0][`DISC_DELAY_WIDTH-1:0] digital_delay;
  } delay_cfg_t;

  typedef struct packed {
    logic [`DISC_CHANNELS-1:0][`DISC_SOURCE_WIDTH-1:0] source;
    logic [`DISC_CHANNELS-1:0] bypass;
  } trigger_cfg_t;

  typedef struct packed {
    logic [`DISC_CHANNELS-1:0][`DISC_DERIVED_WIDTH-1:0] pipe_delay;
    logic [`DISC_CHANNELS-1:0][`DISC_DERIVED_WIDTH-1:0] total_delay;
    logic [`DISC_DIGITAL_CHANNELS-1:0][`DISC_DERIVED_WIDTH-1:0] digital_delay;
  } derived_delay_t;

  typedef struct packed {
    logic [`DISC_TIME_WIDTH-1:0] clock_time;
    logic [`DISC_INDEX_WIDTH-1:0] sample_index;
  } timestamp_t;

  typedef struct packed {
    timestamp_t [`DISC_CHANNELS-1:0] data;
    logic [`DISC_CHANNELS-1:0] valid;
  } timestamp_bus_t;

  typedef enum logic [1:0] {DISABLED, PRECAPTURE, CAPTURE} chan_state_e;

  // sources past the analog channels are digital inputs
  function automatic logic is_digital_source(input logic [`DISC_SOURCE_WIDTH-1:0] source);
    return int'(source) >= `DISC_CHANNELS;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/discriminator_config.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sample_disc_config.svh"

module discriminator_config (
  input logic adc_clk,
  input logic adc_reset,
  input logic threshold_load,
  input sample_disc_pkg::threshold_cfg_t threshold_cfg,
  input logic delay_load,
  input sample_disc_pkg::delay_cfg_t delay_cfg,
  input logic trigger_load,
  input sample_disc_pkg::trigger_cfg_t trigger_cfg,
  output sample_disc_pkg::threshold_cfg_t thresholds,
  output sample_disc_pkg::derived_delay_t delays,
  output logic [`DISC_CHANNELS-1:0][`DISC_SOURCE_WIDTH-1:0] source,
  output logic [`DISC_CHANNELS-1:0] source_is_digital,
  output logic [`DISC_CHANNELS-1:0] bypass
);
  import sample_disc_pkg::*;

  // detector plus router stages ahead of the beat delay line
  localparam logic [`DISC_DERIVED_WIDTH-1:0] PIPE_LATENCY = 2;
  localparam logic [`DISC_DERIVED_WIDTH-1:0] DIGITAL_LATENCY = 1;

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      thresholds <= '0;
    end else if (threshold_load) begin
      thresholds <= threshold_cfg;
    end
  end

  // derived delays are computed once at load time
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        delays.pipe_delay[ch] <= PIPE_LATENCY;
        delays.total_delay[ch] <= '0;
      end
      for (int d = 0; d < `DISC_DIGITAL_CHANNELS; d++) begin
        delays.digital_delay[d] <= DIGITAL_LATENCY;
      end
    end else if (delay_load) begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        delays.pipe_delay[ch] <= {1'b0, delay_cfg.start_delay[ch]} + PIPE_LATENCY;
        delays.total_delay[ch] <= {1'b0, delay_cfg.start_delay[ch]}
                                  + {1'b0, delay_cfg.stop_delay[ch]};
      end
      for (int d = 0; d < `DISC_DIGITAL_CHANNELS; d++) begin
        delays.digital_delay[d] <= {1'b0, delay_cfg.digital_delay[d]} + DIGITAL_LATENCY;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      // each channel starts on its own analog trigger
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        source[ch] <= ch[`DISC_SOURCE_WIDTH-1:0];
      end
      source_is_digital <= '0;
      bypass <= '0;
    end else if (trigger_load) begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        source[ch] <= trigger_cfg.source[ch];
        source_is_digital[ch] <= is_digital_source(trigger_cfg.source[ch]);
      end
      bypass <= trigger_cfg.bypass;
    end
  end

  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_source_check
    a_source_range: assert property (@(posedge adc_clk) disable iff (adc_reset)
      trigger_load |-> int'(trigger_cfg.source[ch]) < `DISC_CHANNELS + `DISC_DIGITAL_CHANNELS);
  end

endmodule

`default_nettype wire

// ==== verilog/threshold_detector.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sample_disc_config.svh"

module threshold_detector (
  input logic adc_clk,
  input logic adc_reset,
  input sample_disc_pkg::adc_bus_t adc_in,
  input sample_disc_pkg::threshold_cfg_t thresholds,
  output logic [`DISC_CHANNELS-1:0] any_above_high,
  output logic [`DISC_CHANNELS-1:0] all_below_low
);

  logic [`DISC_CHANNELS-1:0] above_high;
  logic [`DISC_CHANNELS-1:0] below_low;

  ////////////////////
  // sample compare
  ////////////////////

  // one sample over high is enough to start
  // every sample must sit at or under low to stop
  always_comb begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      above_high[ch] = 1'b0;
      below_low[ch] = 1'b1;
      for (int s = 0; s < `DISC_PARALLEL_SAMPLES; s++) begin
        if ($signed(adc_in.data[ch][s]) > $signed(thresholds.high[ch])) begin
          above_high[ch] = 1'b1;
        end
        if ($signed(adc_in.data[ch][s]) > $signed(thresholds.low[ch])) begin
          below_low[ch] = 1'b0;
        end
      end
    end
  end

  ////////////////////
  // flag register
  ////////////////////

  // invalid beats never raise a flag
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      any_above_high <= '0;
      all_below_low <= '0;
    end else begin
      any_above_high <= above_high & adc_in.valid;
      all_below_low <= below_low & adc_in.valid;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pulse_delay.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sample_disc_config.svh"

module pulse_delay #(
  parameter int WIDTH = `DISC_DERIVED_WIDTH
) (
  input logic clk,
  input logic reset,
  input logic [WIDTH-1:0] delay,
  input logic in_pls,
  output logic out_pls
);

  logic [WIDTH-1:0] count;
  logic active;

  // fires on the last cycle of the countdown
  assign out_pls = active && (count == WIDTH'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      active <= 1'b0;
    end else if (in_pls) begin
      // a new pulse restarts the wait
      count <= delay;
      active <= |delay;
    end else if (out_pls) begin
      active <= 1'b0;
    end else if (active) begin
      count <= count - 1'b1;
    end
  end

  // back to back pulses only come from a reload with a delay of one
  a_single_pulse: assert property (@(posedge clk) disable iff (reset)
    out_pls && !(in_pls && (delay == WIDTH'(1))) |=> !out_pls);

endmodule

`default_nettype wire

// ==== verilog/trigger_router.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sample_disc_config.svh"

module trigger_router (
  input logic adc_clk,
  input logic adc_reset,
  input logic reset_state,
  input logic [`DISC_CHANNELS-1:0] any_above_high,
  input logic [`DISC_CHANNELS-1:0] all_below_low,
  input logic [`DISC_DIGITAL_CHANNELS-1:0] digital_trigger,
  input sample_disc_pkg::derived_delay_t delays,
  input logic [`DISC_CHANNELS-1:0][`DISC_SOURCE_WIDTH-1:0] source,
  output logic [`DISC_CHANNELS-1:0] fsm_start,
  output logic [`DISC_CHANNELS-1:0] fsm_start_d,
  output logic [`DISC_CHANNELS-1:0] fsm_stop,
  output logic [`DISC_CHANNELS-1:0] fsm_stop_d
);

  // digital delay reaches MAX_DELAY, total delay reaches 2*(MAX_DELAY-1)
  localparam int DIG_DEPTH = `DISC_MAX_DELAY;
  localparam int STOP_DEPTH = 2 * `DISC_MAX_DELAY - 2;

  logic [DIG_DEPTH-1:0][`DISC_DIGITAL_CHANNELS-1:0] dig_pipe;
  logic [DIG_DEPTH:0][`DISC_DIGITAL_CHANNELS-1:0] dig_taps;
  logic [`DISC_DIGITAL_CHANNELS-1:0] dig_delayed;
  logic [STOP_DEPTH-1:0][`DISC_CHANNELS-1:0] stop_pipe;
  logic [STOP_DEPTH:0][`DISC_CHANNELS-1:0] stop_taps;
  logic [`DISC_CHANNELS+`DISC_DIGITAL_CHANNELS-1:0] start_sources;
  logic [`DISC_CHANNELS+`DISC_DIGITAL_CHANNELS-1:0] stop_sources;

  ////////////////////
  // delay lines
  ////////////////////

  // tap k is the input k cycles ago, tap 0 is the live input
  assign dig_taps = {dig_pipe, digital_trigger};
  assign stop_taps = {stop_pipe, fsm_stop};

  always_ff @(posedge adc_clk) begin
    if (adc_reset || reset_state) begin
      dig_pipe <= '0;
      stop_pipe <= '0;
    end else begin
      dig_pipe <= dig_taps[DIG_DEPTH-1:0];
      stop_pipe <= stop_taps[STOP_DEPTH-1:0];
    end
  end

  always_comb begin
    for (int d = 0; d < `DISC_DIGITAL_CHANNELS; d++) begin
      dig_delayed[d] = dig_taps[delays.digital_delay[d]][d];
    end
  end

  ////////////////////
  // source select
  ////////////////////

  // analog sources first, then digital inputs
  // digital inputs never stop a capture
  assign start_sources = {dig_delayed, any_above_high};
  assign stop_sources = {{`DISC_DIGITAL_CHANNELS{1'b0}}, all_below_low};

  always_ff @(posedge adc_clk) begin
    if (adc_reset || reset_state) begin
      fsm_start <= '0;
      fsm_stop <= '0;
    end else begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        fsm_start[ch] <= start_sources[source[ch]];
        fsm_stop[ch] <= stop_sources[source[ch]];
      end
    end
  end

  // stop is a plain shift so no stop event is dropped
  always_comb begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      fsm_stop_d[ch] = stop_taps[delays.total_delay[ch]][ch];
    end
  end

  // start restarts its countdown on every new trigger
  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_start_delay
    pulse_delay #(
      .WIDTH(`DISC_DERIVED_WIDTH)
    ) start_delay_i (
      .clk(adc_clk),
      .reset(adc_reset || reset_state),
      .delay(delays.total_delay[ch]),
      .in_pls(fsm_start[ch]),
      .out_pls(fsm_start_d[ch])
    );
  end

endmodule

`default_nettype wire

// ==== verilog/capture_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sample_disc_config.svh"

module capture_fsm (
  input logic adc_clk,
  input logic adc_reset,
  input logic reset_state,
  input sample_disc_pkg::adc_bus_t adc_in,
  input sample_disc_pkg::derived_delay_t delays,
  input logic [`DISC_CHANNELS-1:0] source_is_digital,
  input logic [`DISC_CHANNELS-1:0] bypass,
  input logic [`DISC_CHANNELS-1:0] fsm_start,
  input logic [`DISC_CHANNELS-1:0] fsm_start_d,
  input logic [`DISC_CHANNELS-1:0] fsm_stop,
  input logic [`DISC_CHANNELS-1:0] fsm_stop_d,
  output sample_disc_pkg::adc_bus_t adc_out,
  output sample_disc_pkg::timestamp_bus_t timestamps_out
);
  import sample_disc_pkg::*;

  // largest pipe delay is MAX_DELAY-1 plus two
  localparam int PIPE_DEPTH = `DISC_MAX_DELAY + 2;

  chan_state_e state [`DISC_CHANNELS];
  logic [`DISC_CHANNELS-1:0] has_delay;
  sample_beat_t [PIPE_DEPTH-1:0][`DISC_CHANNELS-1:0] beat_pipe;
  logic [PIPE_DEPTH-1:0][`DISC_CHANNELS-1:0] valid_pipe;
  logic [`DISC_TIME_WIDTH-1:0] time_count;
  logic [`DISC_CHANNELS-1:0][`DISC_INDEX_WIDTH-1:0] out_index;
  logic [`DISC_CHANNELS-1:0] armed;
  timestamp_t [`DISC_CHANNELS-1:0] ts_data;
  logic [`DISC_CHANNELS-1:0] ts_valid;

  always_comb begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      has_delay[ch] = |delays.total_delay[ch];
    end
  end

  ////////////////////
  // channel state
  ////////////////////

  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      if (adc_reset || reset_state) begin
        state[ch] <= DISABLED;
      end else begin
        unique case (state[ch])
          DISABLED: begin
            if (fsm_start[ch]) begin
              state[ch] <= has_delay[ch] ? PRECAPTURE : CAPTURE;
            end
          end
          PRECAPTURE: begin
            // digital windows close when the countdown runs out
            if (fsm_start_d[ch]) begin
              state[ch] <= source_is_digital[ch] ? DISABLED : CAPTURE;
            end
          end
          CAPTURE: begin
            if (fsm_start[ch]) begin
              state[ch] <= has_delay[ch] ? PRECAPTURE : CAPTURE;
            end else if (has_delay[ch] ? fsm_stop_d[ch] : fsm_stop[ch]) begin
              state[ch] <= DISABLED;
            end
          end
          default: state[ch] <= DISABLED;
        endcase
      end
    end
  end

  ////////////////////
  // beat delay line
  ////////////////////

  // beat_pipe[k] holds the beat that entered k+1 cycles ago
  always_ff @(posedge adc_clk) begin
    beat_pipe <= {beat_pipe[PIPE_DEPTH-2:0], adc_in.data};
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[PIPE_DEPTH-2:0], adc_in.valid};
    end
  end

  // gated by the state in the same cycle the beat leaves
  always_comb begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      adc_out.data[ch] = beat_pipe[delays.pipe_delay[ch]][ch];
      adc_out.valid[ch] = valid_pipe[delays.pipe_delay[ch]][ch]
                          & ((state[ch] != DISABLED) | bypass[ch]);
    end
  end

  ////////////////////
  // timestamps
  ////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      time_count <= '0;
    end else begin
      time_count <= time_count + 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset || reset_state) begin
      out_index <= '0;
    end else begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        if (adc_out.valid[ch]) begin
          out_index[ch] <= out_index[ch] + 1'b1;
        end
      end
    end
  end

  // armed on activation and fired by the next valid output beat
  always_ff @(posedge adc_clk) begin
    if (adc_reset || reset_state) begin
      armed <= '0;
      ts_valid <= '0;
    end else begin
      ts_valid <= armed & adc_out.valid;
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        if (armed[ch] && adc_out.valid[ch]) begin
          armed[ch] <= 1'b0;
        end
        if ((state[ch] == DISABLED) && fsm_start[ch]) begin
          armed[ch] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      if (armed[ch] && adc_out.valid[ch]) begin
        ts_data[ch] <= '{clock_time: time_count, sample_index: out_index[ch]};
      end
    end
  end

  assign timestamps_out = '{data: ts_data, valid: ts_valid};

  // a stamp follows its output beat and carries the index that beat used
  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_ts_check
    a_ts_after_beat: assert property (@(posedge adc_clk) disable iff (adc_reset)
      timestamps_out.valid[ch] |-> $past(adc_out.valid[ch])
        && (out_index[ch] == timestamps_out.data[ch].sample_index + 1'b1));
  end

endmodule

`default_nettype wire

// ==== verilog/sample_discriminator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sample_disc_config.svh"

module sample_discriminator (
  input logic adc_clk,
  input logic adc_reset,
  input logic reset_state,
  input sample_disc_pkg::adc_bus_t adc_in,
  input logic [`DISC_DIGITAL_CHANNELS-1:0] digital_trigger,
  input logic threshold_load,
  input sample_disc_pkg::threshold_cfg_t threshold_cfg,
  input logic delay_load,
  input sample_disc_pkg::delay_cfg_t delay_cfg,
  input logic trigger_load,
  input sample_disc_pkg::trigger_cfg_t trigger_cfg,
  output sample_disc_pkg::adc_bus_t adc_out,
  output sample_disc_pkg::timestamp_bus_t timestamps_out
);
  import sample_disc_pkg::*;

  threshold_cfg_t thresholds;
  derived_delay_t delays;
  logic [`DISC_CHANNELS-1:0][`DISC_SOURCE_WIDTH-1:0] source;
  logic [`DISC_CHANNELS-1:0] source_is_digital;
  logic [`DISC_CHANNELS-1:0] bypass;
  logic [`DISC_CHANNELS-1:0] any_above_high;
  logic [`DISC_CHANNELS-1:0] all_below_low;
  logic [`DISC_CHANNELS-1:0] fsm_start;
  logic [`DISC_CHANNELS-1:0] fsm_start_d;
  logic [`DISC_CHANNELS-1:0] fsm_stop;
  logic [`DISC_CHANNELS-1:0] fsm_stop_d;

  discriminator_config config_i (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .threshold_load(threshold_load),
    .threshold_cfg(threshold_cfg),
    .delay_load(delay_load),
    .delay_cfg(delay_cfg),
    .trigger_load(trigger_load),
    .trigger_cfg(trigger_cfg),
    .thresholds(thresholds),
    .delays(delays),
    .source(source),
    .source_is_digital(source_is_digital),
    .bypass(bypass)
  );

  threshold_detector detector_i (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .adc_in(adc_in),
    .thresholds(thresholds),
    .any_above_high(any_above_high),
    .all_below_low(all_below_low)
  );

  trigger_router router_i (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .any_above_high(any_above_high),
    .all_below_low(all_below_low),
    .digital_trigger(digital_trigger),
    .delays(delays),
    .source(source),
    .fsm_start(fsm_start),
    .fsm_start_d(fsm_start_d),
    .fsm_stop(fsm_stop),
    .fsm_stop_d(fsm_stop_d)
  );

  capture_fsm fsm_i (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .adc_in(adc_in),
    .delays(delays),
    .source_is_digital(source_is_digital),
    .bypass(bypass),
    .fsm_start(fsm_start),
    .fsm_start_d(fsm_start_d),
    .fsm_stop(fsm_stop),
    .fsm_stop_d(fsm_stop_d),
    .adc_out(adc_out),
    .timestamps_out(timestamps_out)
  );

endmodule

`default_nettype wire

// ==== dv/sample_discriminator_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sample_disc_config.svh"

module sample_discriminator_tb;
  import sample_disc_pkg::*;

  localparam int NCH = `DISC_CHANNELS;
  localparam int NDIG = `DISC_DIGITAL_CHANNELS;
  localparam int SRC_W = `DISC_SOURCE_WIDTH;
  localparam int HIST = 2 * `DISC_MAX_DELAY;
  localparam int RUN_CYCLES = 300;
  // ten traffic runs plus config loads, reset and margin
  localparam int WATCHDOG_CYCLES = 10 * (RUN_CYCLES + 5) + 50;

  logic adc_clk;
  logic adc_reset;
  logic reset_state;
  adc_bus_t adc_in;
  logic [NDIG-1:0] digital_trigger;
  logic threshold_load;
  threshold_cfg_t threshold_cfg;
  logic delay_load;
  delay_cfg_t delay_cfg;
  logic trigger_load;
  trigger_cfg_t trigger_cfg;
  adc_bus_t adc_out;
  timestamp_bus_t timestamps_out;

  // cycle model state, hist[k] is the value k cycles ago
  threshold_cfg_t m_thr;
  delay_cfg_t m_dly;
  trigger_cfg_t m_trig;
  logic [NCH-1:0] m_above;
  logic [NCH-1:0] m_below;
  logic [NCH-1:0] m_start;
  logic [NCH-1:0] m_stop;
  logic [NCH-1:0] m_active;
  int m_count [NCH];
  chan_state_e m_state [NCH];
  logic [NDIG-1:0] m_dig_hist [HIST+1];
  logic [NCH-1:0] m_stop_hist [HIST+1];
  logic [NCH-1:0] m_valid_hist [HIST+1];
  sample_beat_t m_beat_hist [HIST+1][NCH];
  logic [`DISC_TIME_WIDTH-1:0] m_time;
  logic [`DISC_INDEX_WIDTH-1:0] m_index [NCH];
  logic [NCH-1:0] m_armed;
  logic [NCH-1:0] m_ts_valid;
  timestamp_t m_ts [NCH];

  logic [31:0] rng_state = 32'h494c;
  string test_name;
  int test_errors;
  int ts_seen;
  int tests_run;
  int tests_failed;
  int total_errors;
  int wait_cycles;
  int bypass_delays [3] = '{0, 7, 15};
  delay_cfg_t dly_v;
  trigger_cfg_t trig_v;

  sample_discriminator dut_i (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .adc_in(adc_in),
    .digital_trigger(digital_trigger),
    .threshold_load(threshold_load),
    .threshold_cfg(threshold_cfg),
    .delay_load(delay_load),
    .delay_cfg(delay_cfg),
    .trigger_load(trigger_load),
    .trigger_cfg(trigger_cfg),
    .adc_out(adc_out),
    .timestamps_out(timestamps_out)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog expired after %0d cycles, run aborted", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

  ////////////////////
  // random numbers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_bits();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic threshold_cfg_t random_thresholds();
    threshold_cfg_t t;
    for (int ch = 0; ch < NCH; ch++) begin
      t.high[ch] = 16'h1000 + 16'(rand_bits() % 24576);
      t.low[ch] = 16'(rand_bits() % 4096);
    end
    return t;
  endfunction

  // min_start of 1 keeps the total delay nonzero
  function automatic delay_cfg_t random_delays(input int min_start);
    delay_cfg_t d;
    for (int ch = 0; ch < NCH; ch++) begin
      d.start_delay[ch] = 4'(min_start + int'(rand_bits() % (16 - min_start)));
      d.stop_delay[ch] = 4'(min_start + int'(rand_bits() % (16 - min_start)));
    end
    for (int i = 0; i < NDIG; i++) begin
      d.digital_delay[i] = 4'(rand_bits() % 16);
    end
    return d;
  endfunction

  function automatic trigger_cfg_t analog_sources(input logic [NCH-1:0] bypass);
    trigger_cfg_t g;
    for (int ch = 0; ch < NCH; ch++) begin
      g.source[ch] = SRC_W'(ch);
    end
    g.bypass = bypass;
    return g;
  endfunction

  ////////////////////
  // cycle model
  ////////////////////

  function automatic int total_delay(input int ch);
    return int'(m_dly.start_delay[ch]) + int'(m_dly.stop_delay[ch]);
  endfunction

  // a beat leaves start_delay+3 cycles after it entered
  function automatic int out_age(input int ch);
    return int'(m_dly.start_delay[ch]) + 3;
  endfunction

  function automatic logic expected_valid(input int ch);
    return m_valid_hist[out_age(ch)][ch] && (m_state[ch] != DISABLED || m_trig.bypass[ch]);
  endfunction

  task automatic clear_state();
    for (int ch = 0; ch < NCH; ch++) begin
      m_state[ch] = DISABLED;
      m_index[ch] = '0;
      m_count[ch] = 0;
    end
    m_armed = '0;
    m_ts_valid = '0;
    m_start = '0;
    m_stop = '0;
    m_active = '0;
    for (int k = 0; k <= HIST; k++) begin
      m_dig_hist[k] = '0;
      m_stop_hist[k] = '0;
    end
  endtask

  task automatic next_state(input int ch, input logic start_d, input logic stop_d);
    logic has_delay;
    has_delay = total_delay(ch) != 0;
    case (m_state[ch])
      DISABLED: begin
        if (m_start[ch]) begin
          m_state[ch] = has_delay ? PRECAPTURE : CAPTURE;
        end
      end
      PRECAPTURE: begin
        if (start_d) begin
          m_state[ch] = is_digital_source(m_trig.source[ch]) ? DISABLED : CAPTURE;
        end
      end
      default: begin
        if (m_start[ch]) begin
          m_state[ch] = has_delay ? PRECAPTURE : CAPTURE;
        end else if (has_delay ? stop_d : m_stop[ch]) begin
          m_state[ch] = DISABLED;
        end
      end
    endcase
  endtask

  // one rising edge, every update reads the values from before the edge
  task automatic model_clock();
    logic [NCH-1:0] ov;
    logic [NCH-1:0] start_d;
    logic [NCH-1:0] stop_d;
    logic [NDIG-1:0] dig_del;
    logic [NCH+NDIG-1:0] starts;
    int src;
    if (adc_reset) begin
      m_thr = '0;
      m_dly = '0;
      m_trig = analog_sources('0);
      m_above = '0;
      m_below = '0;
      m_time = '0;
      for (int k = 0; k <= HIST; k++) begin
        m_valid_hist[k] = '0;
      end
      clear_state();
    end else begin
      for (int ch = 0; ch < NCH; ch++) begin
        ov[ch] = expected_valid(ch);
        start_d[ch] = m_active[ch] && (m_count[ch] == 1);
        stop_d[ch] = (total_delay(ch) == 0) ? m_stop[ch] : m_stop_hist[total_delay(ch)][ch];
        if (m_armed[ch] && ov[ch]) begin
          m_ts[ch].clock_time = m_time;
          m_ts[ch].sample_index = m_index[ch];
        end
      end
      for (int i = 0; i < NDIG; i++) begin
        dig_del[i] = m_dig_hist[int'(m_dly.digital_delay[i]) + 1][i];
      end
      if (reset_state) begin
        clear_state();
      end else begin
        for (int ch = 0; ch < NCH; ch++) begin
          m_ts_valid[ch] = m_armed[ch] && ov[ch];
          if (m_armed[ch] && ov[ch]) begin
            m_armed[ch] = 1'b0;
          end
          if (m_state[ch] == DISABLED && m_start[ch]) begin
            m_armed[ch] = 1'b1;
          end
          if (ov[ch]) begin
            m_index[ch] = m_index[ch] + 1'b1;
          end
          next_state(ch, start_d[ch], stop_d[ch]);
          // start countdown, a new start reloads it
          if (m_start[ch]) begin
            m_count[ch] = total_delay(ch);
            m_active[ch] = total_delay(ch) != 0;
          end else if (start_d[ch]) begin
            m_active[ch] = 1'b0;
          end else if (m_active[ch]) begin
            m_count[ch] = m_count[ch] - 1;
          end
        end
        for (int k = HIST; k > 1; k--) begin
          m_stop_hist[k] = m_stop_hist[k-1];
          m_dig_hist[k] = m_dig_hist[k-1];
        end
        m_stop_hist[1] = m_stop;
        m_dig_hist[1] = digital_trigger;
        starts = {dig_del, m_above};
        for (int ch = 0; ch < NCH; ch++) begin
          src = int'(m_trig.source[ch]);
          m_start[ch] = starts[src];
          m_stop[ch] = is_digital_source(m_trig.source[ch]) ? 1'b0 : m_below[src];
        end
      end
      m_time = m_time + 1'b1;
      for (int ch = 0; ch < NCH; ch++) begin
        m_above[ch] = 1'b0;
        m_below[ch] = adc_in.valid[ch];
        for (int s = 0; s < `DISC_PARALLEL_SAMPLES; s++) begin
          if ($signed(adc_in.data[ch][s]) > $signed(m_thr.high[ch])) begin
            m_above[ch] = adc_in.valid[ch];
          end
          if ($signed(adc_in.data[ch][s]) > $signed(m_thr.low[ch])) begin
            m_below[ch] = 1'b0;
          end
        end
      end
      for (int k = HIST; k > 1; k--) begin
        m_valid_hist[k] = m_valid_hist[k-1];
      end
      m_valid_hist[1] = adc_in.valid;
      if (threshold_load) begin
        m_thr = threshold_cfg;
      end
      if (delay_load) begin
        m_dly = delay_cfg;
      end
      if (trigger_load) begin
        m_trig = trigger_cfg;
      end
    end
    for (int k = HIST; k > 1; k--) begin
      m_beat_hist[k] = m_beat_hist[k-1];
    end
    for (int ch = 0; ch < NCH; ch++) begin
      m_beat_hist[1][ch] = adc_in.data[ch];
    end
  endtask

  ////////////////////
  // stimulus and checks
  ////////////////////

  task automatic report_mismatch(input string what, input int ch, input logic [63:0] exp,
                                 input logic [63:0] act);
    test_errors++;
    $display("error %s: ch%0d %s expected %h actual %h", test_name, ch, what, exp, act);
  endtask

  task automatic check_outputs();
    logic exp_v;
    for (int ch = 0; ch < NCH; ch++) begin
      exp_v = expected_valid(ch);
      if (adc_out.valid[ch] !== exp_v) begin
        report_mismatch("adc_out.valid", ch, exp_v, adc_out.valid[ch]);
      end else if (exp_v && adc_out.data[ch] !== m_beat_hist[out_age(ch)][ch]) begin
        report_mismatch("adc_out.data", ch, m_beat_hist[out_age(ch)][ch], adc_out.data[ch]);
      end
      if (timestamps_out.valid[ch] !== m_ts_valid[ch]) begin
        report_mismatch("timestamp valid", ch, m_ts_valid[ch], timestamps_out.valid[ch]);
      end else if (m_ts_valid[ch] && timestamps_out.data[ch] !== m_ts[ch]) begin
        report_mismatch("timestamp", ch, m_ts[ch], timestamps_out.data[ch]);
      end
      if (timestamps_out.valid[ch] === 1'b1) begin
        ts_seen++;
      end
    end
  endtask

  task automatic run_cycle();
    @(posedge adc_clk);
    model_clock();
    @(negedge adc_clk);
    if (!adc_reset) begin
      check_outputs();
    end
  endtask

  // quiet beats sit below any low threshold and end analog captures
  task automatic drive_random(input int dig_odds);
    logic quiet;
    for (int ch = 0; ch < NCH; ch++) begin
      quiet = (rand_bits() % 4) == 0;
      adc_in.valid[ch] = (rand_bits() % 8) != 0;
      for (int s = 0; s < `DISC_PARALLEL_SAMPLES; s++) begin
        adc_in.data[ch][s] = quiet ? 16'hffff - 16'(rand_bits() % 4096) : 16'(rand_bits());
      end
    end
    for (int i = 0; i < NDIG; i++) begin
      digital_trigger[i] = (dig_odds != 0) && ((rand_bits() % dig_odds) == 0);
    end
  endtask

  task automatic run_traffic(input int cycles, input int dig_odds);
    repeat (cycles) begin
      drive_random(dig_odds);
      run_cycle();
    end
  endtask

  task automatic load_config(input threshold_cfg_t thr, input delay_cfg_t dly,
                             input trigger_cfg_t trig);
    threshold_cfg = thr;
    delay_cfg = dly;
    trigger_cfg = trig;
    threshold_load = 1'b1;
    delay_load = 1'b1;
    trigger_load = 1'b1;
    drive_random(0);
    run_cycle();
    threshold_load = 1'b0;
    delay_load = 1'b0;
    trigger_load = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
    ts_seen = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d mismatches", test_name, (test_errors == 0) ? "ok" : "FAILED",
             test_errors);
  endtask

  initial begin
    adc_reset = 1'b1;
    reset_state = 1'b0;
    adc_in = '0;
    digital_trigger = '0;
    threshold_load = 1'b0;
    threshold_cfg = '0;
    delay_load = 1'b0;
    delay_cfg = '0;
    trigger_load = 1'b0;
    trigger_cfg = '0;
    tests_run = 0;
    tests_failed = 0;
    total_errors = 0;
    repeat (5) run_cycle();
    adc_reset = 1'b0;

    begin_test("bypass");
    foreach (bypass_delays[i]) begin
      dly_v = random_delays(0);
      for (int ch = 0; ch < NCH; ch++) begin
        dly_v.start_delay[ch] = 4'(bypass_delays[i]);
      end
      load_config(random_thresholds(), dly_v, analog_sources('1));
      run_traffic(RUN_CYCLES, 0);
    end
    end_test();

    begin_test("analog");
    load_config(random_thresholds(), '0, analog_sources('0));
    run_traffic(RUN_CYCLES, 0);
    end_test();

    begin_test("delayed");
    load_config(random_thresholds(), random_delays(1), analog_sources('0));
    run_traffic(RUN_CYCLES, 0);
    end_test();

    begin_test("digital");
    trig_v = analog_sources('0);
    for (int ch = 0; ch < NCH; ch++) begin
      trig_v.source[ch] = SRC_W'(NCH + ch);
    end
    load_config(random_thresholds(), random_delays(1), trig_v);
    run_traffic(RUN_CYCLES, 24);
    end_test();

    begin_test("timestamps");
    load_config(random_thresholds(), random_delays(0), analog_sources('0));
    run_traffic(RUN_CYCLES, 0);
    if (ts_seen == 0) begin
      test_errors++;
      $display("error timestamps: the DUT emitted no timestamp in the whole run");
    end
    end_test();

    begin_test("reset_state");
    load_config(random_thresholds(), random_delays(1), analog_sources('0));
    wait_cycles = 0;
    while (m_state[0] == DISABLED && wait_cycles < RUN_CYCLES) begin
      drive_random(0);
      run_cycle();
      wait_cycles++;
    end
    if (m_state[0] == DISABLED) begin
      test_errors++;
      $display("error reset_state: channel 0 never started a capture");
    end
    run_traffic(2, 0);
    reset_state = 1'b1;
    drive_random(0);
    run_cycle();
    reset_state = 1'b0;
    run_traffic(RUN_CYCLES, 0);
    end_test();

    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
verilog/sample_disc_pkg.sv
verilog/discriminator_config.sv
verilog/threshold_detector.sv
verilog/pulse_delay.sv
verilog/trigger_router.sv
verilog/capture_fsm.sv
verilog/sample_discriminator.sv
dv/sample_discriminator_tb.sv

// ==== Bender.yml ====
package:
  name: sample_discriminator

export_include_dirs:
  - include

sources:
  - verilog/sample_disc_pkg.sv
  - verilog/discriminator_config.sv
  - verilog/threshold_detector.sv
  - verilog/pulse_delay.sv
  - verilog/trigger_router.sv
  - verilog/capture_fsm.sv
  - verilog/sample_discriminator.sv
  - target: simulation
    files:
      - dv/sample_discriminator_tb.sv
